//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  exit 1
fi

//--- rv_core.f
rv_isa_pkg.sv
rv_core_pkg.sv
rv_pipe_if.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_tb.sv

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  input  rv_isa_pkg::inst_t     inst_i,
  output logic                  wb_valid_o,
  output rv_isa_pkg::reg_addr_t wb_rd_o,
  output rv_isa_pkg::word_t     wb_data_o
);

  // result value of the instruction now in execute-to-result
  rv_isa_pkg::word_t res_data;

  dec_ex_if dx_if ();
  ex_res_if xr_if ();

  // decode also owns the register file
  rv_decode u_decode (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o),
    .wb_data_i    (wb_data_o),
    .dx           (dx_if.producer)
  );

  // forwards from result and from the write-back bus
  rv_execute u_execute (
    .clk        (clk),
    .rst        (rst),
    .res_data_i (res_data),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o),
    .dx         (dx_if.consumer),
    .xr         (xr_if.producer)
  );

  rv_result u_result (
    .clk        (clk),
    .rst        (rst),
    .xr         (xr_if.consumer),
    .res_data_o (res_data),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

//--- rv_core_pkg.sv
package rv_core_pkg;

  // alu function, picked in decode
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // where the rd value comes from
  typedef enum logic [0:0] {
    RD_SRC_ALU = 1'b0,
    RD_SRC_IMM = 1'b1
  } rd_src_e;

  // d keeps all 64 bits, w sign-extends the low word
  typedef enum logic [0:0] {
    RD_EXT_D = 1'b0,
    RD_EXT_W = 1'b1
  } rd_ext_e;

  // execute controls, 6 bits
  typedef struct packed {
    alu_op_e alu_op;
    // second operand is the immediate
    logic    use_imm;
    logic    use_rs1;
    logic    use_rs2;
  } ex_ctrl_t;

  // result controls, 2 bits
  typedef struct packed {
    rd_src_e rd_src;
    rd_ext_e rd_ext;
  } wb_ctrl_t;

endpackage

//--- rv_core_stim.txt
// columns: instruction word, expected wb rd, expected 64-bit wb data (hex)
// dependent addi / lui chains first, then alu ops, shifts, word ops, x0
00500093 01 0000000000000005
00708113 02 000000000000000C
FFF10193 03 000000000000000B
00218233 04 0000000000000017
800002B7 05 FFFFFFFF80000000
12345337 06 0000000012345000
67830313 06 0000000012345678
405303B3 07 0000000092345678
FFF3C413 08 FFFFFFFF6DCBA987
03D09493 09 A000000000000000
0212D513 0A 000000007FFFFFFF
4244D593 0B FFFFFFFFFA000000
0F05E613 0C FFFFFFFFFA0000F0
7FF67693 0D 00000000000000F0
00D09733 0E 0005000000000000
00D4D7B3 0F 000000000000A000
40D4D833 10 FFFFFFFFFFFFA000
00F848B3 11 FFFFFFFFFFFF0000
00E7E933 12 000500000000A000
0128F9B3 13 0005000000000000
00138A1B 14 FFFFFFFF92345679
00730ABB 15 FFFFFFFFA468ACF0
40208B3B 16 FFFFFFFFFFFFFFF9
06408013 00 0000000000000069
00100BB3 17 0000000000000005

//--- rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  // capacity of the stimulus memory, in entries
  localparam int MAX_ENTRIES = 64;

  // one expected write-back, due is the cycle count of its strobe
  typedef struct packed {
    logic [4:0]  rd;
    logic [63:0] data;
    logic [31:0] due;
  } wb_exp_t;

  logic        clk;
  logic        rst;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [63:0] wb_data_o;

  // three words per entry: instruction, rd, data
  logic [63:0] stim_mem [0:3*MAX_ENTRIES-1];
  int          num_entries;
  logic [31:0] cycle_cnt;
  logic [31:0] cycle_limit;
  logic [31:0] lcg_state;
  // in program order, oldest first
  wb_exp_t     exp_q [$];

  rv_core u_rv_core (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_sim(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAILED time %0t: %s = %h, expected %h", $time, name, got, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // edge counter, also bounds the run
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 32'd1;
    if (cycle_cnt >= cycle_limit) begin
      abort_sim($sformatf("timeout: write-backs still missing after %0d cycles", cycle_cnt));
    end
  end

  // outputs are settled half a period after the edge
  always @(negedge clk) begin
    if ((exp_q.size() > 0) && (cycle_cnt == exp_q[0].due)) begin
      check("wb_valid_o", 64'(wb_valid_o), 64'd1);
      check("wb_rd_o", 64'(wb_rd_o), 64'(exp_q[0].rd));
      check("wb_data_o", wb_data_o, exp_q[0].data);
      void'(exp_q.pop_front());
    end else if (wb_valid_o) begin
      // also covers reset and an empty queue
      abort_sim($sformatf("write-back strobe at %0t with no instruction due", $time));
    end
  end

  initial begin
    int      gap;
    wb_exp_t e;
    clk          = 1'b0;
    rst          = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    cycle_cnt    = '0;
    cycle_limit  = '1;
    lcg_state    = 32'h1360;

    // all-ones never matches a 32-bit instruction, marks the end
    for (int i = 0; i < 3*MAX_ENTRIES; i++) begin
      stim_mem[i] = '1;
    end
    $readmemh("rv_core_stim.txt", stim_mem);
    num_entries = 0;
    while ((num_entries < MAX_ENTRIES) && (stim_mem[3*num_entries] != '1)) begin
      num_entries++;
    end
    if (num_entries == 0) begin
      abort_sim("no entries read from rv_core_stim.txt");
    end
    // reset, worst-case issue with gaps, drain
    cycle_limit = 32'(16 + 3*num_entries + 20);

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int n = 0; n < num_entries; n++) begin
      @(posedge clk);
      #1;
      inst_valid_i = 1'b1;
      inst_i       = stim_mem[3*n][31:0];
      e.rd         = stim_mem[3*n+1][4:0];
      e.data       = stim_mem[3*n+2];
      // sampled at the next edge, strobe three edges after that
      e.due        = cycle_cnt + 32'd4;
      exp_q.push_back(e);
      // idle gap of 0..2 cycles
      lcg_state = lcg_next(lcg_state);
      gap       = int'((lcg_state >> 16) % 32'd3);
      repeat (gap) begin
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
      end
    end
    @(posedge clk);
    #1;
    inst_valid_i = 1'b0;
    inst_i       = '0;

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // no stray strobes after the last one
    repeat (4) @(negedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  input  rv_isa_pkg::inst_t     inst_i,
  input  logic                  wb_valid_i,
  input  rv_isa_pkg::reg_addr_t wb_rd_i,
  input  rv_isa_pkg::word_t     wb_data_i,
  dec_ex_if.producer            dx
);

  // instruction register ahead of the decoder
  logic                  inst_valid_q;
  rv_isa_pkg::inst_t     inst_q;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     imm_d;
  logic                  opc_ok;
  rv_core_pkg::ex_ctrl_t ex_ctrl_d;
  rv_core_pkg::wb_ctrl_t wb_ctrl_d;

  // x1..x31, x0 reads as zero
  rv_isa_pkg::word_t     regs [1:31];
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;

  // funct3 to alu op, alt bits choose sub / sra
  function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3,
                                                   input logic alt_add,
                                                   input logic alt_sr);
    rv_core_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::F3_ADD: op = alt_add ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL: op = rv_core_pkg::ALU_SLL;
      rv_isa_pkg::F3_XOR: op = rv_core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:  op = alt_sr ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:  op = rv_core_pkg::ALU_OR;
      rv_isa_pkg::F3_AND: op = rv_core_pkg::ALU_AND;
      default:            op = rv_core_pkg::ALU_ADD;
    endcase
    return op;
  endfunction

  // read port, same-cycle write-back passes straight through
  function automatic rv_isa_pkg::word_t rf_read(input rv_isa_pkg::reg_addr_t a);
    rv_isa_pkg::word_t v;
    if (a == '0) begin
      v = '0;
    end else if (wb_valid_i && (wb_rd_i == a)) begin
      v = wb_data_i;
    end else begin
      v = regs[a];
    end
    return v;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    inst_q <= inst_i;
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rs1    = inst_q[19:15];
  assign rs2    = inst_q[24:20];
  assign rd     = inst_q[11:7];

  // i-type, low six bits double as shamt
  assign imm_i = {{(rv_isa_pkg::XLEN - 12){inst_q[31]}}, inst_q[31:20]};
  // u-type, upper word sign-filled
  assign imm_u = {{(rv_isa_pkg::XLEN - 32){inst_q[31]}}, inst_q[31:12], 12'b0};

  always_comb begin
    opc_ok    = 1'b1;
    ex_ctrl_d = '0;
    wb_ctrl_d = '0;
    imm_d     = imm_i;
    case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        // value taken from imm in result, alu result unused
        wb_ctrl_d.rd_src  = rv_core_pkg::RD_SRC_IMM;
        imm_d             = imm_u;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        // srai marks bit 30, shamt[5] sits in bit 25
        ex_ctrl_d.alu_op  = alu_sel(funct3, 1'b0, funct7[6:1] == rv_isa_pkg::F7_ALT[6:1]);
        ex_ctrl_d.use_imm = 1'b1;
        ex_ctrl_d.use_rs1 = 1'b1;
      end
      rv_isa_pkg::OPC_OP: begin
        ex_ctrl_d.alu_op  = alu_sel(funct3, funct7 == rv_isa_pkg::F7_ALT,
                                    funct7 == rv_isa_pkg::F7_ALT);
        ex_ctrl_d.use_rs1 = 1'b1;
        ex_ctrl_d.use_rs2 = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM_32: begin
        // addiw only
        ex_ctrl_d.use_imm = 1'b1;
        ex_ctrl_d.use_rs1 = 1'b1;
        wb_ctrl_d.rd_ext  = rv_core_pkg::RD_EXT_W;
      end
      rv_isa_pkg::OPC_OP_32: begin
        // addw / subw
        ex_ctrl_d.alu_op  = (funct7 == rv_isa_pkg::F7_ALT) ? rv_core_pkg::ALU_SUB
                                                           : rv_core_pkg::ALU_ADD;
        ex_ctrl_d.use_rs1 = 1'b1;
        ex_ctrl_d.use_rs2 = 1'b1;
        wb_ctrl_d.rd_ext  = rv_core_pkg::RD_EXT_W;
      end
      default: begin
        opc_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    rs1_data = rf_read(rs1);
    rs2_data = rf_read(rs2);
  end

  // write port, x0 never stored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid_i && (wb_rd_i != '0)) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // decode to execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= inst_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    dx.ex_ctrl  <= ex_ctrl_d;
    dx.wb_ctrl  <= wb_ctrl_d;
    dx.rs1      <= rs1;
    dx.rs2      <= rs2;
    dx.rd       <= rd;
    dx.rs1_data <= rs1_data;
    dx.rs2_data <= rs2_data;
    dx.imm      <= imm_d;
  end

  // an accepted instruction must decode to a known opcode one cycle on
  a_opc_supported: assert property (@(posedge clk) disable iff (rst)
    inst_valid_i |=> opc_ok);

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::word_t     res_data_i,
  input  logic                  wb_valid_i,
  input  rv_isa_pkg::reg_addr_t wb_rd_i,
  input  rv_isa_pkg::word_t     wb_data_i,
  dec_ex_if.consumer            dx,
  ex_res_if.producer            xr
);

  // older instructions that will write a register
  logic              xr_wr;
  logic              wb_wr;
  rv_isa_pkg::word_t rs1_val;
  rv_isa_pkg::word_t rs2_val;
  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t op_b;
  rv_isa_pkg::word_t alu_y;
  logic [5:0]        shamt;

  assign xr_wr = xr.valid && (xr.rd != '0);
  assign wb_wr = wb_valid_i && (wb_rd_i != '0);

  // youngest producer wins, result stage over write-back
  always_comb begin
    rs1_val = dx.rs1_data;
    if (xr_wr && (xr.rd == dx.rs1)) begin
      rs1_val = res_data_i;
    end else if (wb_wr && (wb_rd_i == dx.rs1)) begin
      rs1_val = wb_data_i;
    end
  end

  always_comb begin
    rs2_val = dx.rs2_data;
    if (xr_wr && (xr.rd == dx.rs2)) begin
      rs2_val = res_data_i;
    end else if (wb_wr && (wb_rd_i == dx.rs2)) begin
      rs2_val = wb_data_i;
    end
  end

  // unused sources forced to zero
  assign op_a = dx.ex_ctrl.use_rs1 ? rs1_val : '0;
  assign op_b = dx.ex_ctrl.use_imm ? dx.imm :
                dx.ex_ctrl.use_rs2 ? rs2_val : '0;

  // rv64 shift range
  assign shamt = op_b[5:0];

  always_comb begin
    case (dx.ex_ctrl.alu_op)
      rv_core_pkg::ALU_ADD: alu_y = op_a + op_b;
      rv_core_pkg::ALU_SUB: alu_y = op_a - op_b;
      rv_core_pkg::ALU_XOR: alu_y = op_a ^ op_b;
      rv_core_pkg::ALU_OR:  alu_y = op_a | op_b;
      rv_core_pkg::ALU_AND: alu_y = op_a & op_b;
      rv_core_pkg::ALU_SLL: alu_y = op_a << shamt;
      rv_core_pkg::ALU_SRL: alu_y = op_a >> shamt;
      rv_core_pkg::ALU_SRA: alu_y = $signed(op_a) >>> shamt;
      default:              alu_y = '0;
    endcase
  end

  // execute to result register
  always_ff @(posedge clk) begin
    if (rst) begin
      xr.valid <= 1'b0;
    end else begin
      xr.valid <= dx.valid;
    end
  end

  always_ff @(posedge clk) begin
    xr.wb_ctrl <= dx.wb_ctrl;
    xr.rd      <= dx.rd;
    xr.alu_out <= alu_y;
    xr.imm     <= dx.imm;
  end

  // x0 as a source reads zero, whatever is in flight
  a_x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    dx.valid |-> ((dx.rs1 != '0) || (rs1_val == '0)) &&
                 ((dx.rs2 != '0) || (rs2_val == '0)));

endmodule

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // integer register width, rv64
  localparam int XLEN = 64;

  // data word, as held in the register file
  typedef logic [XLEN-1:0] word_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // register index, x0..x31
  typedef logic [4:0] reg_addr_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP = 7'b0110011;

  // word forms, result sign-extended from bit 31
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32 = 7'b0111011;

  // funct3, inst[14:12]
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  // srl and sra share this code
  localparam logic [2:0] F3_SR = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 picking sub over add, sra over srl
  // for the immediate shifts only the upper six bits count
  localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

//--- rv_pipe_if.sv
`timescale 1ns/1ps

// decode to execute, one register stage
interface dec_ex_if;
  // strobe, qualifies all fields this cycle
  logic                  valid;
  rv_core_pkg::ex_ctrl_t ex_ctrl;
  rv_core_pkg::wb_ctrl_t wb_ctrl;
  // source indices kept for forwarding compares
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::reg_addr_t rd;
  // register file values as read in decode
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;
  rv_isa_pkg::word_t     imm;

  modport producer (output valid, ex_ctrl, wb_ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm);
  modport consumer (input valid, ex_ctrl, wb_ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm);
endinterface

// execute to result
interface ex_res_if;
  logic                  valid;
  rv_core_pkg::wb_ctrl_t wb_ctrl;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::word_t     alu_out;
  // lui value bypasses the alu
  rv_isa_pkg::word_t     imm;

  modport producer (output valid, wb_ctrl, rd, alu_out, imm);
  modport consumer (input valid, wb_ctrl, rd, alu_out, imm);
endinterface

//--- rv_result.sv
`timescale 1ns/1ps

module rv_result (
  input  logic                  clk,
  input  logic                  rst,
  ex_res_if.consumer            xr,
  output rv_isa_pkg::word_t     res_data_o,
  output logic                  wb_valid_o,
  output rv_isa_pkg::reg_addr_t wb_rd_o,
  output rv_isa_pkg::word_t     wb_data_o
);

  // selected value before extension
  rv_isa_pkg::word_t raw;

  always_comb begin
    raw = (xr.wb_ctrl.rd_src == rv_core_pkg::RD_SRC_IMM) ? xr.imm : xr.alu_out;
    // w ops keep the low word, sign from bit 31
    if (xr.wb_ctrl.rd_ext == rv_core_pkg::RD_EXT_W) begin
      res_data_o = {{(rv_isa_pkg::XLEN - 32){raw[31]}}, raw[31:0]};
    end else begin
      res_data_o = raw;
    end
  end

  // write-back register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= xr.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= xr.rd;
    wb_data_o <= res_data_o;
  end

  // lui carries a u-type immediate, low twelve bits clear
  a_lui_imm: assert property (@(posedge clk) disable iff (rst)
    xr.valid && (xr.wb_ctrl.rd_src == rv_core_pkg::RD_SRC_IMM) |-> (xr.imm[11:0] == '0));

endmodule
